//--- source/ising_config.svh
`ifndef ISING_CONFIG_SVH
`define ISING_CONFIG_SVH

// number of spins in the model
`define ISING_NUM_SPIN 16

// bit width of one signed coupling weight J_ij
`define ISING_BITJ 4

// bit width of one signed bias h_i
`define ISING_BITH 4

// bit width of the power-of-two scale field for h
`define ISING_SCALING_BIT 5

// register stages behind the adder tree in the calculator
`define ISING_PIPES 1

`endif

//--- source/ising_pkg.sv
`include "ising_config.svh"

package ising_pkg;

    // ==================================================
    // derived widths
    // ==================================================
    localparam int NUM_SPIN = `ISING_NUM_SPIN;
    localparam int BITJ     = `ISING_BITJ;
    localparam int IDX_W    = $clog2(`ISING_NUM_SPIN);
    // product of bias and scale, sign bit counted once
    localparam int MULT_W   = `ISING_BITH + `ISING_SCALING_BIT - 1;
    // width of the raw weight sum out of the tree
    localparam int WSUM_W   = IDX_W + MULT_W;
    // one extra bit for doubling and the bias term
    localparam int LOCAL_W  = WSUM_W + 1;
    localparam int TOTAL_W  = LOCAL_W + IDX_W;

    // ==================================================
    // shared types
    // ==================================================
    typedef logic [NUM_SPIN*BITJ-1:0]       weight_row_t;
    typedef logic signed [`ISING_BITH-1:0]  hbias_t;
    typedef logic [`ISING_SCALING_BIT-1:0]  hscale_t;
    typedef logic [NUM_SPIN-1:0]            spin_vec_t;
    typedef logic [IDX_W-1:0]               spin_idx_t;
    typedef logic signed [MULT_W-1:0]       mult_t;
    typedef logic signed [LOCAL_W-1:0]      local_energy_t;
    typedef logic signed [TOTAL_W-1:0]      total_energy_t;

endpackage

//--- source/energy_if.sv
`timescale 1ns/1ps

// operands of one spin, sequencer to calculator
interface energy_if import ising_pkg::*; ();

    // one spin's operands are carried on each cycle with valid high
    logic        valid;
    spin_vec_t   spin_vector;
    logic        current_spin;
    weight_row_t weight;
    hbias_t      hbias;
    hscale_t     hscaling;
    logic        double_weight;
    // drops anything in flight before a new request
    logic        flush;

    // sequencer side
    modport src (output valid, spin_vector, current_spin, weight, hbias, hscaling,
                 double_weight, flush);

    // calculator side
    modport dst (input valid, spin_vector, current_spin, weight, hbias, hscaling,
                 double_weight, flush);

endinterface

//--- source/delay_pipe.sv
`timescale 1ns/1ps

module delay_pipe #(
    parameter int DATAW = 1,
    parameter int PIPES = 1
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             flush_i,
    input  logic             valid_i,
    input  logic [DATAW-1:0] data_i,
    output logic             valid_o,
    output logic [DATAW-1:0] data_o
);

    if (PIPES == 0) begin : g_bypass
        // no stages, a flushed item is still dropped
        assign valid_o = valid_i & ~flush_i;
        assign data_o  = data_i;
    end else begin : g_shift
        logic [PIPES-1:0] vld_q;
        logic [DATAW-1:0] data_q [PIPES];

        // valid tags move every cycle, flush empties the line
        always_ff @(posedge clk_i) begin
            if (reset_i || flush_i) begin
                vld_q <= '0;
            end else begin
                vld_q[0] <= valid_i;
                for (int s = 1; s < PIPES; s++) begin
                    vld_q[s] <= vld_q[s-1];
                end
            end
        end

        // a stage only loads when a valid item arrives at it
        always_ff @(posedge clk_i) begin
            if (valid_i) begin
                data_q[0] <= data_i;
            end
            for (int s = 1; s < PIPES; s++) begin
                if (vld_q[s-1]) begin
                    data_q[s] <= data_q[s-1];
                end
            end
        end

        assign valid_o = vld_q[PIPES-1];
        assign data_o  = data_q[PIPES-1];
    end

endmodule

//--- source/adder_tree.sv
`timescale 1ns/1ps

module adder_tree #(
    parameter int N     = 16,
    parameter int DATAW = 8,
    parameter int PIPES = 1
) (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 valid_i,
    input  logic [N-1:0][DATAW-1:0]              data_i,
    output logic signed [DATAW+$clog2(N)-1:0]    sum_o
);

    localparam int LEVELS = $clog2(N);
    // leaf count rounded up to a power of two
    localparam int NPAD   = 1 << LEVELS;
    localparam int SUMW   = DATAW + LEVELS;

    logic signed [SUMW-1:0] tree_sum;

    genvar l, k, s;

    // ==================================================
    // binary reduction, one bit of growth per level
    // ==================================================
    for (l = 0; l <= LEVELS; l++) begin : g_lvl
        logic signed [DATAW+l-1:0] node [NPAD >> l];
        if (l == 0) begin : g_leaf
            for (k = 0; k < NPAD; k++) begin : g_in
                if (k < N) begin : g_term
                    assign node[k] = data_i[k];
                end else begin : g_pad
                    // padding leaves add nothing
                    assign node[k] = '0;
                end
            end
        end else begin : g_sum
            // signed operands, so each pair sign-extends into the wider node
            for (k = 0; k < (NPAD >> l); k++) begin : g_node
                assign node[k] = g_lvl[l-1].node[2*k] + g_lvl[l-1].node[2*k+1];
            end
        end
    end

    assign tree_sum = g_lvl[LEVELS].node[0];

    // ==================================================
    // output stages
    // ==================================================
    if (PIPES == 0) begin : g_comb
        assign sum_o = tree_sum;
    end else begin : g_pipe
        for (s = 0; s < PIPES; s++) begin : g_stage
            logic                   load;
            logic signed [SUMW-1:0] d;
            logic signed [SUMW-1:0] q;
            if (s == 0) begin : g_head
                assign load = valid_i;
                assign d    = tree_sum;
            end else begin : g_body
                assign load = g_stage[s-1].g_tag.vld_q;
                assign d    = g_stage[s-1].q;
            end
            // valid tag, kept only where a later stage needs it
            if (s < PIPES - 1) begin : g_tag
                logic vld_q;
                always_ff @(posedge clk_i) begin
                    if (reset_i) begin
                        vld_q <= 1'b0;
                    end else begin
                        vld_q <= load;
                    end
                end
            end
            // sum reads zero out of reset
            always_ff @(posedge clk_i) begin
                if (reset_i) begin
                    q <= '0;
                end else if (load) begin
                    q <= d;
                end
            end
        end
        assign sum_o = g_stage[PIPES-1].q;
    end

endmodule

//--- source/partial_energy_calc.sv
`timescale 1ns/1ps
`include "ising_config.svh"

module partial_energy_calc import ising_pkg::*; (
    input  logic          clk_i,
    input  logic          reset_i,
    energy_if.dst         op,
    output logic          energy_valid_o,
    output local_energy_t energy_o
);

    // weight terms with the neighbour spin applied
    mult_t [NUM_SPIN-1:0]     term;
    mult_t                    hbias_ext;
    mult_t                    hbias_scaled;
    logic [2:0]               scale_shift;
    logic signed [WSUM_W-1:0] weight_sum;
    // side operands, delayed to line up with the tree output
    mult_t                    hbias_q;
    logic                     double_q;
    logic                     spin_q;
    local_energy_t            weight_part;
    local_energy_t            energy_sum;

    // ==================================================
    // weight terms
    // ==================================================
    always_comb begin
        mult_t w_ext;
        for (int i = 0; i < NUM_SPIN; i++) begin
            // sign extend J_ij, then take -J_ij where spin j is 0
            w_ext   = mult_t'(signed'(op.weight[i*BITJ +: BITJ]));
            term[i] = op.spin_vector[i] ? w_ext : -w_ext;
        end
    end

    adder_tree #(
        .N     (NUM_SPIN),
        .DATAW (MULT_W),
        .PIPES (`ISING_PIPES)
    ) u_adder_tree (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (op.valid),
        .data_i  (term),
        .sum_o   (weight_sum)
    );

    // ==================================================
    // bias scaling
    // ==================================================
    assign hbias_ext = mult_t'(op.hbias);

    // power of two scale to shift, anything else acts as 1
    always_comb begin
        case (op.hscaling)
            5'd2:    scale_shift = 3'd1;
            5'd4:    scale_shift = 3'd2;
            5'd8:    scale_shift = 3'd3;
            5'd16:   scale_shift = 3'd4;
            default: scale_shift = 3'd0;
        endcase
    end

    assign hbias_scaled = hbias_ext <<< scale_shift;

    delay_pipe #(
        .DATAW (MULT_W),
        .PIPES (`ISING_PIPES)
    ) u_pipe_hbias (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (op.flush),
        .valid_i (op.valid),
        .data_i  (hbias_scaled),
        .valid_o (),
        .data_o  (hbias_q)
    );

    delay_pipe #(
        .DATAW (1),
        .PIPES (`ISING_PIPES)
    ) u_pipe_double (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (op.flush),
        .valid_i (op.valid),
        .data_i  (op.double_weight),
        .valid_o (),
        .data_o  (double_q)
    );

    // this copy of the valid bit marks the result
    delay_pipe #(
        .DATAW (1),
        .PIPES (`ISING_PIPES)
    ) u_pipe_spin (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (op.flush),
        .valid_i (op.valid),
        .data_i  (op.current_spin),
        .valid_o (energy_valid_o),
        .data_o  (spin_q)
    );

    // ==================================================
    // local energy
    // ==================================================
    assign weight_part = double_q ? (local_energy_t'(weight_sum) <<< 1)
                                  : local_energy_t'(weight_sum);
    // plus twice the scaled bias
    assign energy_sum  = weight_part + (local_energy_t'(hbias_q) <<< 1);
    // spin 0 counts as -1
    assign energy_o    = spin_q ? energy_sum : -energy_sum;

endmodule

//--- source/coupling_store.sv
`timescale 1ns/1ps

module coupling_store import ising_pkg::*; (
    input  logic        clk_i,
    input  logic        wr_en_i,
    input  spin_idx_t   wr_addr_i,
    input  weight_row_t wr_weight_i,
    input  hbias_t      wr_hbias_i,
    input  spin_idx_t   rd_addr_i,
    output weight_row_t rd_weight_o,
    output hbias_t      rd_hbias_o
);

    // one J row and one h per spin
    weight_row_t weight_mem [NUM_SPIN];
    hbias_t      hbias_mem  [NUM_SPIN];

    // host write port
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            weight_mem[wr_addr_i] <= wr_weight_i;
            hbias_mem[wr_addr_i]  <= wr_hbias_i;
        end
    end

    // registered read, data one cycle behind the address
    always_ff @(posedge clk_i) begin
        rd_weight_o <= weight_mem[rd_addr_i];
        rd_hbias_o  <= hbias_mem[rd_addr_i];
    end

endmodule

//--- source/energy_sequencer.sv
`timescale 1ns/1ps

module energy_sequencer import ising_pkg::*; (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          req_i,
    output logic          ack_o,
    input  spin_vec_t     spins_i,
    input  hscale_t       hscaling_i,
    input  logic          double_weight_i,
    output spin_idx_t     rd_addr_o,
    input  weight_row_t   rd_weight_i,
    input  hbias_t        rd_hbias_i,
    energy_if.src         calc,
    input  logic          energy_valid_i,
    input  local_energy_t energy_i,
    output total_energy_t energy_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_DRAIN,
        ST_DONE
    } state_t;

    state_t        state_q;
    spin_idx_t     addr_q;
    spin_idx_t     count_q;
    // issue strobe and index, one cycle behind the address
    logic          issue_q;
    spin_idx_t     idx_q;
    // request operands held for the whole pass
    spin_vec_t     spins_q;
    hscale_t       hscaling_q;
    logic          double_q;
    total_energy_t total_q;
    logic          start;
    logic          last_result;

    // new request seen in idle, ack is low there
    assign start       = (state_q == ST_IDLE) && req_i;
    assign last_result = energy_valid_i && (count_q == spin_idx_t'(NUM_SPIN - 1));

    // ==================================================
    // control FSM
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (addr_q == spin_idx_t'(NUM_SPIN - 1)) begin
                        state_q <= ST_DRAIN;
                    end
                end
                // wait for the last local energy
                ST_DRAIN: begin
                    if (last_result) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (!req_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // address stepping, result count and total
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            addr_q  <= '0;
            count_q <= '0;
            issue_q <= 1'b0;
            total_q <= '0;
        end else begin
            issue_q <= (state_q == ST_ISSUE);
            if (start) begin
                addr_q  <= '0;
                count_q <= '0;
                total_q <= '0;
            end else begin
                if (state_q == ST_ISSUE) begin
                    addr_q <= addr_q + 1'b1;
                end
                if (energy_valid_i) begin
                    total_q <= total_q + total_energy_t'(energy_i);
                    count_q <= count_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        idx_q <= addr_q;
        if (start) begin
            spins_q    <= spins_i;
            hscaling_q <= hscaling_i;
            double_q   <= double_weight_i;
        end
    end

    // ==================================================
    // calculator operands
    // ==================================================
    assign calc.valid         = issue_q;
    assign calc.flush         = start;
    assign calc.spin_vector   = spins_q;
    assign calc.current_spin  = spins_q[idx_q];
    assign calc.weight        = rd_weight_i;
    assign calc.hbias         = rd_hbias_i;
    assign calc.hscaling      = hscaling_q;
    assign calc.double_weight = double_q;

    assign rd_addr_o = addr_q;
    assign ack_o     = (state_q == ST_DONE);
    assign energy_o  = total_q;

endmodule

//--- source/energy_monitor_top.sv
`timescale 1ns/1ps

module energy_monitor_top import ising_pkg::*; (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          req_i,
    output logic          ack_o,
    input  spin_vec_t     spins_i,
    input  hscale_t       hscaling_i,
    input  logic          double_weight_i,
    input  logic          wr_en_i,
    input  spin_idx_t     wr_addr_i,
    input  weight_row_t   wr_weight_i,
    input  hbias_t        wr_hbias_i,
    output total_energy_t energy_o
);

    // store read port
    spin_idx_t     rd_addr;
    weight_row_t   rd_weight;
    hbias_t        rd_hbias;
    // local energies back from the calculator
    logic          energy_valid;
    local_energy_t local_energy;

    energy_if calc_link ();

    coupling_store u_store (
        .clk_i       (clk_i),
        .wr_en_i     (wr_en_i),
        .wr_addr_i   (wr_addr_i),
        .wr_weight_i (wr_weight_i),
        .wr_hbias_i  (wr_hbias_i),
        .rd_addr_i   (rd_addr),
        .rd_weight_o (rd_weight),
        .rd_hbias_o  (rd_hbias)
    );

    energy_sequencer u_seq (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .req_i           (req_i),
        .ack_o           (ack_o),
        .spins_i         (spins_i),
        .hscaling_i      (hscaling_i),
        .double_weight_i (double_weight_i),
        .rd_addr_o       (rd_addr),
        .rd_weight_i     (rd_weight),
        .rd_hbias_i      (rd_hbias),
        .calc            (calc_link.src),
        .energy_valid_i  (energy_valid),
        .energy_i        (local_energy),
        .energy_o        (energy_o)
    );

    partial_energy_calc u_calc (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .op             (calc_link.dst),
        .energy_valid_o (energy_valid),
        .energy_o       (local_energy)
    );

endmodule

//--- dv/tb_energy_monitor.sv
`timescale 1ns/1ps

module tb_energy_monitor import ising_pkg::*; ();

    localparam int CLK_NS      = 40;
    // cycle budget of one handshake and of one full load of the store
    localparam int REQ_CYCLES  = NUM_SPIN + 20;
    localparam int LOAD_CYCLES = 4 * NUM_SPIN;
    localparam int NUM_TESTS   = 6;
    localparam int REQ_PER_TEST = 8;
    localparam longint WATCHDOG_NS =
        longint'(NUM_TESTS) * (REQ_PER_TEST * REQ_CYCLES + LOAD_CYCLES) * CLK_NS;

    logic          clk_i;
    logic          reset_i;
    logic          req_i;
    logic          ack_o;
    spin_vec_t     spins_i;
    hscale_t       hscaling_i;
    logic          double_weight_i;
    logic          wr_en_i;
    spin_idx_t     wr_addr_i;
    weight_row_t   wr_weight_i;
    hbias_t        wr_hbias_i;
    total_energy_t energy_o;

    // testbench copy of J and h
    weight_row_t   j_model [NUM_SPIN];
    hbias_t        h_model [NUM_SPIN];

    energy_monitor_top u_dut (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .req_i           (req_i),
        .ack_o           (ack_o),
        .spins_i         (spins_i),
        .hscaling_i      (hscaling_i),
        .double_weight_i (double_weight_i),
        .wr_en_i         (wr_en_i),
        .wr_addr_i       (wr_addr_i),
        .wr_weight_i     (wr_weight_i),
        .wr_hbias_i      (wr_hbias_i),
        .energy_o        (energy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    // watchdog sized from the number of tests and their requests
    initial begin
        #(WATCHDOG_NS);
        stop_run("timeout: the tests did not finish within the watchdog time");
    end

    // ==================================================
    // failure reporting and compare tasks
    // ==================================================
    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_energy(input total_energy_t exp, input total_energy_t act,
                                input string name);
        if (act !== exp) begin
            stop_run($sformatf("** Error: %s expected 0x%h got 0x%h", name, exp, act));
        end
    endtask

    task automatic check_ack_low(input string where);
        if (ack_o !== 1'b0) begin
            stop_run($sformatf("** Error: ack_o %s expected 0x0 got 0x%h", where, ack_o));
        end
    endtask

    // ==================================================
    // reference model
    // ==================================================
    function automatic total_energy_t expected_total(input spin_vec_t spins,
                                                     input hscale_t scale, input logic dbl);
        int total;
        int wsum;
        int w;
        int mult;
        int local_e;
        total = 0;
        // scales other than 1, 2, 4, 8 and 16 act as 1
        case (scale)
            5'd1, 5'd2, 5'd4, 5'd8, 5'd16: mult = int'(scale);
            default:                       mult = 1;
        endcase
        for (int i = 0; i < NUM_SPIN; i++) begin
            wsum = 0;
            for (int j = 0; j < NUM_SPIN; j++) begin
                w = int'($signed(j_model[i][j*BITJ +: BITJ]));
                wsum += spins[j] ? w : -w;
            end
            if (dbl) begin
                wsum = 2 * wsum;
            end
            local_e = wsum + 2 * int'(h_model[i]) * mult;
            // spin 0 flips the sign of the local energy
            total += spins[i] ? local_e : -local_e;
        end
        return total_energy_t'(total);
    endfunction

    // ==================================================
    // bus tasks
    // ==================================================
    task automatic write_row(input spin_idx_t idx, input weight_row_t row, input hbias_t h);
        @(negedge clk_i);
        wr_en_i     = 1'b1;
        wr_addr_i   = idx;
        wr_weight_i = row;
        wr_hbias_i  = h;
        j_model[idx] = row;
        h_model[idx] = h;
        @(negedge clk_i);
        wr_en_i = 1'b0;
    endtask

    // bit 0 of mode randomizes J and bit 1 randomizes h
    task automatic load_store(input int mode);
        weight_row_t row;
        hbias_t      h;
        for (int i = 0; i < NUM_SPIN; i++) begin
            row = mode[0] ? {$urandom(), $urandom()} : '0;
            h   = mode[1] ? hbias_t'($urandom()) : '0;
            write_row(spin_idx_t'(i), row, h);
        end
    endtask

    // full four-phase handshake that takes the total while ack_o is high
    task automatic run_request(input spin_vec_t spins, input hscale_t scale, input logic dbl,
                               output total_energy_t result);
        int cycles;
        @(negedge clk_i);
        spins_i         = spins;
        hscaling_i      = scale;
        double_weight_i = dbl;
        req_i           = 1'b1;
        cycles = 0;
        while (!ack_o) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > REQ_CYCLES) begin
                stop_run("ack_o never rose after req_i was raised");
            end
        end
        result = energy_o;
        // ack and the total stay put while the host still holds req
        repeat (2) begin
            @(negedge clk_i);
            if (ack_o !== 1'b1) begin
                stop_run($sformatf("** Error: ack_o under req_i expected 0x1 got 0x%h",
                                   ack_o));
            end
            check_energy(result, energy_o, "energy_o held under ack_o");
        end
        req_i = 1'b0;
        cycles = 0;
        while (ack_o) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > 4) begin
                stop_run("ack_o stayed high after req_i fell");
            end
        end
        check_ack_low("after req_i fell");
    endtask

    task automatic request_and_check(input spin_vec_t spins, input hscale_t scale,
                                     input logic dbl);
        total_energy_t got;
        run_request(spins, scale, dbl, got);
        check_energy(expected_total(spins, scale, dbl), got, "energy_o");
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic test_reset_zero();
        check_ack_low("after reset");
        check_energy('0, energy_o, "energy_o after reset");
        load_store(0);
        request_and_check(spin_vec_t'($urandom()), 5'd1, 1'b0);
    endtask

    task automatic test_random_weights();
        load_store(1);
        request_and_check('1, 5'd1, 1'b0);
        request_and_check('0, 5'd1, 1'b0);
        repeat (3) request_and_check(spin_vec_t'($urandom()), 5'd1, 1'b0);
    endtask

    task automatic test_bias_scaling();
        spin_vec_t     s;
        total_energy_t got;
        load_store(2);
        s = spin_vec_t'($urandom());
        for (int k = 0; k <= 4; k++) begin
            request_and_check(s, hscale_t'(1 << k), 1'b0);
        end
        // illegal scales fall back to 1
        run_request(s, 5'd0, 1'b0, got);
        check_energy(expected_total(s, 5'd1, 1'b0), got, "energy_o at scale 0");
        run_request(s, 5'd3, 1'b0, got);
        check_energy(expected_total(s, 5'd1, 1'b0), got, "energy_o at scale 3");
    endtask

    task automatic test_double_weight();
        spin_vec_t s;
        s = spin_vec_t'($urandom());
        load_store(1);
        request_and_check(s, 5'd1, 1'b0);
        request_and_check(s, 5'd1, 1'b1);
        // with h present only the J part is doubled
        load_store(3);
        request_and_check(s, 5'd4, 1'b0);
        request_and_check(s, 5'd4, 1'b1);
    endtask

    task automatic test_handshake();
        // back-to-back requests with their own spins
        repeat (4) request_and_check(spin_vec_t'($urandom()), hscale_t'($urandom()),
                                     1'($urandom()));
    endtask

    task automatic test_row_rewrite();
        spin_vec_t s;
        s = spin_vec_t'($urandom());
        request_and_check(s, 5'd2, 1'b0);
        write_row(spin_idx_t'($urandom()), {$urandom(), $urandom()}, hbias_t'($urandom()));
        request_and_check(s, 5'd2, 1'b0);
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        int unused_seed;
        unused_seed     = $urandom(56);
        reset_i         = 1'b1;
        req_i           = 1'b0;
        spins_i         = '0;
        hscaling_i      = 5'd1;
        double_weight_i = 1'b0;
        wr_en_i         = 1'b0;
        wr_addr_i       = '0;
        wr_weight_i     = '0;
        wr_hbias_i      = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        @(negedge clk_i);
        test_reset_zero();
        test_random_weights();
        test_bias_scaling();
        test_double_weight();
        test_handshake();
        test_row_rewrite();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+source
source/ising_pkg.sv
source/energy_if.sv
source/delay_pipe.sv
source/adder_tree.sv
source/partial_energy_calc.sv
source/coupling_store.sv
source/energy_sequencer.sv
source/energy_monitor_top.sv
dv/tb_energy_monitor.sv
